/* all.f */
+incdir+verilog
verilog/mac_mem_pkg.sv
verilog/bus_slot_seq.sv
verilog/rom_disk_loader.sv
verilog/reset_stretcher.sv
verilog/cpu_mem_port.sv
verilog/word_ram.sv
verilog/mac_mem_top.sv
dv/tb_clock.sv
dv/tb_mac_mem.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_mac_mem \
	--Mdir obj_dir -o tb_mac_mem \
	-f all.f

./obj_dir/tb_mac_mem | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* dv/tb_mac_mem.sv */
// testbench top; runs download and cpu handshakes on the memory subsystem, checks by assertions
`timescale 1ns/1ps
`default_nettype none
`include "mac_mem_consts.svh"

module tb_mac_mem;
	import mac_mem_pkg::*;

	localparam int CYCLE_LIMIT = 4000;  // whole run needs well under 1000

	logic        clk8;
	logic        reset;
	logic        reset_req;
	logic        mem_config;
	logic [1:0]  disk_eject;
	logic        dl_downloading;
	logic        dl_req;
	dl_word_t    dl_word;
	logic        dl_ack;
	logic        cpu_req;
	cpu_req_t    cpu_bus;
	logic        cpu_ack;
	logic [15:0] cpu_rdata;
	logic        sys_reset;
	logic [1:0]  disk_inserted;
	logic [1:0]  disk_sides;

	int          errors;
	int          checks;
	int          cycles;
	logic [31:0] lfsr;
	logic [15:0] sb [0:(1 << `RAM_AW)-1];  // expected memory by low word address

	tb_clock u_clk (.clk8(clk8), .reset(reset));

	mac_mem_top dut (
		.clk8(clk8), .reset(reset), .reset_req(reset_req), .mem_config(mem_config),
		.disk_eject(disk_eject), .dl_downloading(dl_downloading), .dl_req(dl_req),
		.dl_word(dl_word), .dl_ack(dl_ack), .cpu_req(cpu_req), .cpu_bus(cpu_bus),
		.cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata), .sys_reset(sys_reset),
		.disk_inserted(disk_inserted), .disk_sides(disk_sides)
	);

	// ------------------------------
	// helpers
	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(output logic [15:0] v);
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr_next(lfsr);  // one step per bit
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic expect_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("error: %s", what);
	endtask

	// one four-phase download word, data from the lfsr
	task automatic download_word(input logic [1:0] index, input logic [20:0] offset);
		logic [15:0] data;
		logic [20:0] waddr;
		int          wait_n;
		take_bits(data);
		case (index)
			2'd0:    waddr = `ROM_BASE + offset;
			2'd1:    waddr = `DSK_INT_BASE + offset;
			default: waddr = `DSK_EXT_BASE + offset;
		endcase
		dl_word.index  = index;
		dl_word.offset = offset;
		dl_word.data   = data;
		dl_req         = 1'b1;
		wait_n         = 0;
		while (!dl_ack) begin
			@(negedge clk8);
			wait_n++;
		end
		checks++;
		assert (wait_n <= 4) else report_problem("dl_ack came later than one slot round");
		sb[waddr[`RAM_AW-1:0]] = data;
		dl_req = 1'b0;
		@(negedge clk8);
		while (dl_ack) @(negedge clk8);  // ack returns low
	endtask

	// one four-phase cpu access; checks the port stayed closed during sys_reset
	task automatic cpu_access(input logic [21:0] addr, input logic we, input logic [1:0] strobes,
			input logic disk, input logic [15:0] wdata, output logic [15:0] rdata);
		int   wait_n;
		int   low_n;
		logic saw_reset;
		cpu_bus.addr      = addr;
		cpu_bus.wdata     = wdata;
		cpu_bus.uds       = strobes[1];
		cpu_bus.lds       = strobes[0];
		cpu_bus.we        = we;
		cpu_bus.disk_byte = disk;
		cpu_req           = 1'b1;
		wait_n    = 0;
		low_n     = sys_reset ? 0 : 1;
		saw_reset = sys_reset;
		while (!cpu_ack) begin
			@(negedge clk8);
			wait_n++;
			if (sys_reset) begin
				low_n     = 0;
				saw_reset = 1'b1;
			end else if (!cpu_ack) begin
				low_n++;  // issue and capture after release
			end
		end
		checks++;
		assert (low_n >= 2) else report_problem("cpu_ack came while sys_reset held the port");
		if (!saw_reset) begin
			checks++;
			assert (wait_n >= 2 && wait_n <= 5) else report_problem("cpu access latency not 2 to 5");
		end
		rdata   = cpu_rdata;
		cpu_req = 1'b0;
		@(negedge clk8);
		while (cpu_ack) @(negedge clk8);
	endtask

	task automatic write_bytes(input logic [20:0] waddr, input logic [1:0] strobes);
		logic [15:0]        data;
		logic [15:0]        rd;
		logic [`RAM_AW-1:0] i;
		take_bits(data);
		i = waddr[`RAM_AW-1:0];
		cpu_access({waddr, 1'b0}, 1'b1, strobes, 1'b0, data, rd);
		if (strobes[1])
			sb[i][15:8] = data[15:8];
		if (strobes[0])
			sb[i][7:0] = data[7:0];
	endtask

	task automatic read_word(input logic [20:0] waddr);
		logic [15:0] rd;
		cpu_access({waddr, 1'b0}, 1'b0, 2'b11, 1'b0, 16'h0000, rd);
		expect_eq("cpu_rdata", rd, sb[waddr[`RAM_AW-1:0]]);
	endtask

	// floppy byte comes doubled, odd address picks the low byte
	task automatic read_disk_byte(input logic [20:0] waddr, input logic odd);
		logic [15:0] rd;
		logic [15:0] w;
		w = sb[waddr[`RAM_AW-1:0]];
		cpu_access({waddr, odd}, 1'b0, 2'b11, 1'b1, 16'h0000, rd);
		expect_eq("cpu_rdata", rd, odd ? {w[7:0], w[7:0]} : {w[15:8], w[15:8]});
	endtask

	// call on the falling edge right after the last reset source ended
	task automatic measure_reset_hold();
		int n;
		n = 0;
		while (sys_reset) begin
			@(negedge clk8);
			n++;
		end
		expect_eq("sys_reset hold", 16'(n), `RESET_HOLD);
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	// ------------------------------
	// protocol checks
	a_reset_state : assert property (@(posedge clk8)
		reset |=> (!dl_ack && !cpu_ack && sys_reset && (disk_inserted == 2'b00)))
		else report_problem("outputs not idle after reset");

	a_req_source : assert property (@(posedge clk8) disable iff (reset)
		reset_req |=> sys_reset)
		else report_problem("reset_req did not raise sys_reset");

	// read data only moves together with a fresh ack
	a_rdata_hold : assert property (@(posedge clk8) disable iff (reset)
		!$stable(cpu_rdata) |-> $rose(cpu_ack))
		else report_problem("cpu_rdata changed without a new cpu_ack");

	always @(posedge clk8) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			report_problem("run did not finish within the cycle limit");
			finish_run();
		end
	end

	// ------------------------------
	// stimulus
	initial begin
		logic [15:0] rd;
		reset_req = 1'b0;
		mem_config = 1'b0;
		disk_eject = 2'b00;
		dl_downloading = 1'b0;
		dl_req = 1'b0;
		dl_word = '0;
		cpu_req = 1'b0;
		cpu_bus = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		lfsr = 32'hdece8a41;

		@(negedge reset);
		expect_eq("sys_reset", 16'(sys_reset), 16'h0001);
		expect_eq("dl_ack", 16'(dl_ack), 16'h0000);
		expect_eq("cpu_ack", 16'(cpu_ack), 16'h0000);
		expect_eq("disk_inserted", 16'(disk_inserted), 16'h0000);
		measure_reset_hold();

		// rom image, cpu kept in reset meanwhile
		dl_downloading = 1'b1;
		for (int i = 0; i < 4; i++) begin
			download_word(2'd0, 21'(i));
			expect_eq("sys_reset", 16'(sys_reset), 16'h0001);
		end
		dl_downloading = 1'b0;
		measure_reset_hold();
		for (int i = 0; i < 4; i++)
			read_word(`ROM_BASE + 21'(i));

		write_bytes(21'd1, 2'b10);  // upper only
		read_word(21'd1);
		write_bytes(21'd2, 2'b01);  // lower only
		read_word(21'd2);

		// internal disk, double sided
		dl_downloading = 1'b1;
		download_word(2'd1, 21'h20);
		download_word(2'd1, 21'h21);
		download_word(2'd1, `DSK_DS_LAST);
		dl_downloading = 1'b0;
		@(negedge clk8);
		expect_eq("disk_inserted", 16'(disk_inserted), 16'h0001);
		expect_eq("disk_sides", 16'(disk_sides), 16'h0001);

		// external disk, single sided
		dl_downloading = 1'b1;
		download_word(2'd2, 21'h40);
		download_word(2'd2, `DSK_SS_LAST);
		dl_downloading = 1'b0;
		@(negedge clk8);
		expect_eq("disk_inserted", 16'(disk_inserted), 16'h0003);
		expect_eq("disk_sides", 16'(disk_sides), 16'h0001);

		read_disk_byte(`DSK_INT_BASE + 21'h20, 1'b0);
		read_disk_byte(`DSK_INT_BASE + 21'h21, 1'b1);
		read_disk_byte(`DSK_EXT_BASE + 21'h40, 1'b0);
		read_disk_byte(`DSK_EXT_BASE + 21'h40, 1'b1);

		// blanked read while a download is open
		dl_downloading = 1'b1;
		cpu_access(22'h000000, 1'b0, 2'b11, 1'b0, 16'h0000, rd);
		expect_eq("cpu_rdata", rd, 16'hffff);
		dl_downloading = 1'b0;
		@(negedge clk8);
		disk_eject = 2'b01;
		@(negedge clk8);
		disk_eject = 2'b00;
		expect_eq("disk_inserted", 16'(disk_inserted), 16'h0002);
		expect_eq("disk_sides", 16'(disk_sides), 16'h0000);

		// config change, then a reset pulse
		mem_config = 1'b1;
		@(negedge clk8);
		expect_eq("sys_reset", 16'(sys_reset), 16'h0001);
		read_word(21'd0);  // waits out the stretch
		reset_req = 1'b1;
		@(negedge clk8);
		reset_req = 1'b0;
		expect_eq("sys_reset", 16'(sys_reset), 16'h0001);
		measure_reset_hold();
		read_word(21'd3);

		finish_run();
	end

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
// clock and power-on reset source for the testbench; instantiate once in the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk8,
	output logic reset
);

	// 40 ns period
	initial begin
		clk8 = 1'b0;
		forever #20 clk8 = ~clk8;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk8);  // two edges in reset
		@(negedge clk8);
		reset = 1'b0;  // released on a falling edge
	end

endmodule

`default_nettype wire

/* verilog/mac_mem_top.sv */
// memory-side top; ties sequencer, loader, reset, cpu port and memory to the external ports
`timescale 1ns/1ps
`default_nettype none

module mac_mem_top (
	input  wire                   clk8,
	input  wire                   reset,
	input  wire                   reset_req,
	input  wire                   mem_config,
	input  wire  [1:0]            disk_eject,
	input  wire                   dl_downloading,
	input  wire                   dl_req,
	input  mac_mem_pkg::dl_word_t dl_word,
	output logic                  dl_ack,
	input  wire                   cpu_req,
	input  mac_mem_pkg::cpu_req_t cpu_bus,
	output logic                  cpu_ack,
	output logic [15:0]           cpu_rdata,
	output logic                  sys_reset,
	output logic [1:0]            disk_inserted,
	output logic [1:0]            disk_sides
);
	import mac_mem_pkg::*;

	bus_slot_t   slot;
	mem_cmd_t    dl_cmd;     // from loader
	mem_cmd_t    cpu_cmd;    // from cpu port
	mem_cmd_t    ram_cmd;    // slot winner
	logic [15:0] rd_data;
	logic        rom_loading;

	bus_slot_seq u_seq (.clk8(clk8), .reset(reset), .slot(slot));

	rom_disk_loader u_loader (
		.clk8(clk8), .reset(reset),
		.dl_downloading(dl_downloading), .dl_req(dl_req), .dl_word(dl_word), .dl_ack(dl_ack),
		.slot(slot), .disk_eject(disk_eject), .mem_cmd(dl_cmd), .rom_loading(rom_loading),
		.disk_inserted(disk_inserted), .disk_sides(disk_sides)
	);

	reset_stretcher u_rst (
		.clk8(clk8), .reset(reset), .reset_req(reset_req),
		.rom_loading(rom_loading), .mem_config(mem_config), .sys_reset(sys_reset)
	);

	cpu_mem_port u_cpu (
		.clk8(clk8), .reset(reset), .sys_reset(sys_reset),
		.cpu_req(cpu_req), .cpu_bus(cpu_bus), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
		.slot(slot), .downloading(dl_downloading), .mem_cmd(cpu_cmd), .rd_data(rd_data)
	);

	// ------------------------------
	// slots are exclusive, a mux is the whole arbiter
	assign ram_cmd = (slot == SLOT_DL) ? dl_cmd : cpu_cmd;

	word_ram u_ram (.clk8(clk8), .cmd(ram_cmd), .rd_data(rd_data));

	// loader and cpu port never drive the memory in the same cycle
	a_no_clash : assert property (
		@(posedge clk8) disable iff (reset)
		!((dl_cmd.we) && (cpu_cmd.we || cpu_cmd.re))
	) else $error("mac_mem_top: loader and cpu access collide");

endmodule

`default_nettype wire

/* verilog/word_ram.sv */
// stand-in for the sdram; small synchronous word memory with byte write and registered read
`timescale 1ns/1ps
`default_nettype none
`include "mac_mem_consts.svh"

module word_ram (
	input  wire                   clk8,
	input  mac_mem_pkg::mem_cmd_t cmd,
	output logic [15:0]           rd_data
);
	import mac_mem_pkg::*;

	localparam int DEPTH = 1 << `RAM_AW;

	logic [15:0]          mem [0:DEPTH-1];
	logic [`RAM_AW-1:0]   waddr;  // upper address bits dropped

	assign waddr = cmd.addr[`RAM_AW-1:0];

	// ------------------------------
	// byte lane writes
	always_ff @(posedge clk8) begin
		if (cmd.we) begin
			if (cmd.be[1])
				mem[waddr][15:8] <= cmd.data[15:8];
			if (cmd.be[0])
				mem[waddr][7:0] <= cmd.data[7:0];
		end
	end

	// read data one cycle after the command
	always_ff @(posedge clk8) begin
		if (cmd.re)
			rd_data <= mem[waddr];
	end

	// one port, never both in a cycle
	a_one_op : assert property (
		@(posedge clk8) !(cmd.we && cmd.re)
	) else $error("word_ram: read and write together");

endmodule

`default_nettype wire

/* verilog/cpu_mem_port.sv */
// cpu memory port; runs cpu accesses in the cpu slot and shapes the returned word
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_port (
	input  wire                    clk8,
	input  wire                    reset,
	input  wire                    sys_reset,
	input  wire                    cpu_req,
	input  mac_mem_pkg::cpu_req_t  cpu_bus,
	output logic                   cpu_ack,
	output logic [15:0]            cpu_rdata,
	input  mac_mem_pkg::bus_slot_t slot,
	input  wire                    downloading,
	output mac_mem_pkg::mem_cmd_t  mem_cmd,
	input  wire  [15:0]            rd_data
);
	import mac_mem_pkg::*;

	logic        take;     // access goes out this cycle
	logic        pend;     // issued, memory answers now
	logic        pend_rd;  // issued access was a read
	logic [15:0] rd_mux;

	assign take = cpu_req && !cpu_ack && !pend && !sys_reset && (slot == SLOT_CPU);

	always_comb begin
		mem_cmd.addr = cpu_bus.addr[21:1];  // byte to word address
		mem_cmd.data = cpu_bus.wdata;
		mem_cmd.be   = {cpu_bus.uds, cpu_bus.lds};
		mem_cmd.we   = take && cpu_bus.we;
		mem_cmd.re   = take && !cpu_bus.we;
	end

	// ------------------------------
	// read data shaping
	// screen stays black while an image loads, disk bytes come doubled
	always_comb begin
		if (downloading)
			rd_mux = 16'hffff;
		else if (cpu_bus.disk_byte)
			rd_mux = cpu_bus.addr[0] ? {rd_data[7:0], rd_data[7:0]}
			                         : {rd_data[15:8], rd_data[15:8]};
		else
			rd_mux = rd_data;
	end

	always_ff @(posedge clk8) begin
		if (reset) begin
			pend    <= 1'b0;
			pend_rd <= 1'b0;
			cpu_ack <= 1'b0;
		end else if (take) begin
			pend    <= 1'b1;
			pend_rd <= !cpu_bus.we;
		end else if (pend) begin
			pend    <= 1'b0;
			cpu_ack <= 1'b1;  // same edge as the data
		end else if (cpu_ack && !cpu_req) begin
			cpu_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk8) begin
		if (pend && pend_rd)
			cpu_rdata <= rd_mux;  // held until next read completes
	end

	// ack answers a request that was up when it rose
	a_ack_with_req : assert property (
		@(posedge clk8) disable iff (reset)
		$rose(cpu_ack) |-> $past(cpu_req)
	) else $error("cpu_mem_port: ack rose without req");

endmodule

`default_nettype wire

/* verilog/reset_stretcher.sv */
// stretched system reset; any source reloads the hold count, the cpu side waits on sys_reset
`timescale 1ns/1ps
`default_nettype none
`include "mac_mem_consts.svh"

module reset_stretcher (
	input  wire  clk8,
	input  wire  reset,
	input  wire  reset_req,    // user reset pulse
	input  wire  rom_loading,  // keep cpu quiet while rom changes
	input  wire  mem_config,   // memory size select
	output logic sys_reset
);

	logic [15:0] rst_cnt;
	logic        mem_config_q;  // last cycle's config
	logic        reload;

	assign reload = reset || reset_req || rom_loading || (mem_config != mem_config_q);

	always_ff @(posedge clk8) begin
		mem_config_q <= mem_config;  // follows input, reset or not
		if (reload)
			rst_cnt <= `RESET_HOLD;
		else if (rst_cnt != 16'd0)
			rst_cnt <= rst_cnt - 16'd1;  // hold runs out
	end

	assign sys_reset = (rst_cnt != 16'd0);

	// every source shows on sys_reset the next cycle
	a_source_hold : assert property (
		@(posedge clk8) disable iff (reset)
		(reset_req || rom_loading) |=> sys_reset
	) else $error("reset_stretcher: source did not raise sys_reset");

endmodule

`default_nettype wire

/* verilog/rom_disk_loader.sv */
// download writer; places rom and floppy images in the shared memory and reports disk type
`timescale 1ns/1ps
`default_nettype none
`include "mac_mem_consts.svh"

module rom_disk_loader (
	input  wire                    clk8,
	input  wire                    reset,
	input  wire                    dl_downloading,  // level, wraps a whole image
	input  wire                    dl_req,
	input  mac_mem_pkg::dl_word_t  dl_word,
	output logic                   dl_ack,
	input  mac_mem_pkg::bus_slot_t slot,
	input  wire  [1:0]             disk_eject,      // per drive, from the os
	output mac_mem_pkg::mem_cmd_t  mem_cmd,
	output logic                   rom_loading,
	output logic [1:0]             disk_inserted,
	output logic [1:0]             disk_sides
);
	import mac_mem_pkg::*;

	logic        wr_fire;    // word goes to memory this cycle
	logic [20:0] base;       // region base of the current word
	logic [1:0]  last_idx;   // index of last accepted word
	logic [20:0] last_off;   // its offset, decides the image size
	logic        dl_down_q;
	logic        dl_fell;
	logic [1:0]  dsk_ds;     // double sided image per drive
	logic [1:0]  dsk_ss;     // single sided image per drive

	// ------------------------------
	// word write
	always_comb begin
		case (dl_word.index)
			2'd0:    base = `ROM_BASE;
			2'd1:    base = `DSK_INT_BASE;
			default: base = `DSK_EXT_BASE;  // 2, and 3 falls in here too
		endcase
	end

	assign wr_fire = dl_req && !dl_ack && (slot == SLOT_DL);  // only the spare slot

	always_comb begin
		mem_cmd.addr = base + dl_word.offset;
		mem_cmd.data = dl_word.data;
		mem_cmd.be   = 2'b11;  // whole words only
		mem_cmd.we   = wr_fire;
		mem_cmd.re   = 1'b0;   // loader never reads
	end

	always_ff @(posedge clk8) begin
		if (reset) begin
			dl_ack    <= 1'b0;
			last_idx  <= 2'd3;  // no image yet
			dl_down_q <= 1'b0;
		end else begin
			dl_down_q <= dl_downloading;
			if (wr_fire) begin
				dl_ack   <= 1'b1;  // cycle after the write
				last_idx <= dl_word.index;
			end else if (dl_ack && !dl_req) begin
				dl_ack <= 1'b0;  // four-phase return
			end
		end
	end

	// offset is payload, follows last_idx
	always_ff @(posedge clk8) begin
		if (wr_fire)
			last_off <= dl_word.offset;
	end

	// ------------------------------
	// image size at end of download
	assign dl_fell = dl_down_q && !dl_downloading;

	always_ff @(posedge clk8) begin
		if (reset) begin
			dsk_ds <= 2'b00;
			dsk_ss <= 2'b00;
		end else begin
			for (int d = 0; d < 2; d++) begin
				if (disk_eject[d]) begin  // eject wins
					dsk_ds[d] <= 1'b0;
					dsk_ss[d] <= 1'b0;
				end else if (dl_fell && (last_idx == 2'(d + 1))) begin
					dsk_ds[d] <= (last_off == `DSK_DS_LAST);
					dsk_ss[d] <= (last_off == `DSK_SS_LAST);
				end
			end
		end
	end

	assign disk_inserted = dsk_ds | dsk_ss;  // any known size
	assign disk_sides    = dsk_ds;
	assign rom_loading   = dl_downloading && (last_idx == 2'd0);

	// ack only answers a pending request
	a_ack_needs_req : assert property (
		@(posedge clk8) disable iff (reset)
		$rose(dl_ack) |-> $past(dl_req)
	) else $error("rom_disk_loader: ack rose without req");

	// write sits in the download slot and is answered next cycle
	a_write_slot : assert property (
		@(posedge clk8) disable iff (reset)
		mem_cmd.we |-> (slot == SLOT_DL) ##1 dl_ack
	) else $error("rom_disk_loader: write outside download slot");

endmodule

`default_nettype wire

/* verilog/bus_slot_seq.sv */
// four-slot bus sequencer; drives the video, IO, CPU and download slot to all bus users
`timescale 1ns/1ps
`default_nettype none

module bus_slot_seq (
	input  wire                   clk8,
	input  wire                   reset,
	output mac_mem_pkg::bus_slot_t slot
);
	import mac_mem_pkg::*;

	// ------------------------------
	// slot order
	//   00 video   01 io   10 cpu   11 download
	// one slot per clk8 cycle, whole round every 4 cycles
	// ------------------------------

	always_ff @(posedge clk8) begin
		if (reset) begin
			slot <= SLOT_VIDEO;  // round restarts on video
		end else begin
			slot <= bus_slot_t'(slot + 2'd1);  // wraps dl -> video
		end
	end

	// round never skips or stalls once out of reset
	a_slot_step : assert property (
		@(posedge clk8) disable iff (reset)
		!$past(reset) |-> (slot == bus_slot_t'($past(slot) + 2'd1))
	) else $error("bus_slot_seq: slot did not advance by one");

endmodule

`default_nettype wire

/* verilog/mac_mem_pkg.sv */
// shared types of the memory subsystem; import inside each module that uses them
`default_nettype none

package mac_mem_pkg;

	// ------------------------------
	// bus sequencer slots, in issue order
	typedef enum logic [1:0] {
		SLOT_VIDEO = 2'd0,  // sequenced only
		SLOT_IO    = 2'd1,
		SLOT_CPU   = 2'd2,
		SLOT_DL    = 2'd3   // spare slot, given to downloads
	} bus_slot_t;

	// one word from the download source
	typedef struct packed {
		logic [1:0]  index;   // 0 rom, 1 internal disk, 2 external disk
		logic [20:0] offset;  // word offset inside the image
		logic [15:0] data;
	} dl_word_t;

	// one cpu access, held stable while req is up
	typedef struct packed {
		logic [21:0] addr;       // byte address
		logic [15:0] wdata;
		logic        uds;        // upper byte strobe, active high
		logic        lds;        // lower byte strobe, active high
		logic        we;         // write when set
		logic        disk_byte;  // floppy byte read, needs demux
	} cpu_req_t;

	// command to the word memory
	typedef struct packed {
		logic [20:0] addr;  // word address
		logic [15:0] data;
		logic [1:0]  be;    // {upper, lower}
		logic        we;
		logic        re;
	} mem_cmd_t;

endpackage

`default_nettype wire

/* verilog/mac_mem_consts.svh */
// memory map, disk image sizes and reset timing; include in any block that needs them
`ifndef MAC_MEM_CONSTS_SVH
`define MAC_MEM_CONSTS_SVH

// ------------------------------
// word bases of the download regions
`define ROM_BASE        21'h000000  // os rom at the bottom
`define DSK_INT_BASE    21'h080000  // internal floppy, 512k words up
`define DSK_EXT_BASE    21'h100000  // external floppy, 1M words up

// ------------------------------
// last word offset of a good image, offsets count words
`define DSK_DS_LAST     21'd409599  // 819200 byte image, double sided
`define DSK_SS_LAST     21'd204799  // 409600 byte image, single sided

// reload value of the reset stretcher
`define RESET_HOLD      16'd64

// low word address bits kept by the stand-in memory
`define RAM_AW          12

`endif
